/* Bender.yml */
package:
  name: core

sources:
  - logic/core_pkg.sv
  - logic/core_alu.sv
  - logic/core_regfile.sv
  - logic/core_sequencer.sv
  - logic/core_top.sv
  - target: simulation
    files:
      - dv/core_sva.sv
      - dv/core_tb.sv

/* dv/core_sva.sv */
// Bus and reset assertions for the sequencer, bound into it from the testbench side
`timescale 1ns/1ps

module core_sva import core_pkg::*; (
    input logic  clock,
    input logic  reset_n,
    input logic  ce,
    input logic  we,
    input addr_t address
);

    // Covers every reset cycle after the first edge and the cycle after release
    a_we_reset: assert property (@(posedge clock) !reset_n |=> !we)
        else $error("we high during or right after reset");

    // A store byte needs ce and is strobed only once per address
    a_we_ce: assert property (@(posedge clock) we |-> ce ##1 (!we || $changed(address)))
        else $error("we high with ce low or repeated on the same address");

    // Registers hold with ce low, so the bus address holds too
    a_address_hold: assert property (@(posedge clock) reset_n && !ce |=> $stable(address))
        else $error("address changed in a cycle with ce low");

endmodule

bind core_sequencer core_sva i_core_sva (.*);

/* dv/core_tb.sv */
// Table-driven testbench for core_top; loads short programs, runs them and checks memory
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

    localparam int ROW_CYCLES = 120;
    localparam int K_ALU      = 0;
    localparam int K_INCDEC   = 1;
    localparam int K_MEM      = 2;
    localparam byte_t JC      = 8'h72;
    localparam byte_t JZ      = 8'h74;
    localparam byte_t JS      = 8'h78;

    typedef struct {
        int      kind;
        alu_op_e op;
        logic    size;
        logic    cin;
        byte_t   jcc;
        word_t   a;
        word_t   b;
        logic    rnd_ce;
        word_t   exp_ax;
        word_t   exp_reg;
        logic    exp_marker;
    } row_t;

    logic  clock;
    logic  reset_n;
    logic  ce;
    logic  we;
    addr_t address;
    byte_t data_in;
    byte_t data_out;
    byte_t mem [65536];
    row_t  rows [$];
    int    seed;
    int    errors;
    int    checks;
    int    cur_row;
    logic  rows_ready;

    core_top i_core_top (
        .clock   (clock),
        .reset_n (reset_n),
        .ce      (ce),
        .address (address),
        .in      (data_in),
        .out     (data_out),
        .we      (we)
    );

    always #4 clock = ~clock;

    // Memory model
    // ----------------------------------------
    assign data_in = mem[address];

    always @(posedge clock) begin
        if (we) begin
            mem[address] <= data_out;
        end
    end

    function automatic byte_t fill_byte(int a);
        return a[7:0] ^ a[15:8] ^ 8'hA5;
    endfunction

    function automatic word_t mem_word(addr_t a);
        return {mem[a + 16'd1], mem[a]};
    endfunction

    // Reference ALU giving {CF, ZF, SF, result}
    function automatic logic [18:0] alu_model(alu_op_e op, logic size, logic cin,
                                              word_t a, word_t b);
        int   mask;
        int   x;
        int   y;
        int   full;
        logic cf;
        mask = size ? 'hFFFF : 'hFF;
        x    = a & mask;
        y    = b & mask;
        cf   = 1'b0;
        case (op)
            ADD:      full = x + y;
            ADC:      full = x + y + int'(cin);
            SUB, CMP: full = x - y;
            SBB:      full = x - y - int'(cin);
            OR:       full = x | y;
            AND:      full = x & y;
            default:  full = x ^ y;
        endcase
        if (op inside {ADD, ADC}) begin
            cf = full > mask;
        end else if (op inside {SUB, SBB, CMP}) begin
            cf = full < 0;
        end
        full = full & mask;
        return {cf, full == 0, size ? full[15] : full[7], word_t'(full)};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h (row %0d)",
                     name, actual, expected, cur_row);
        end
    endtask

    // Stimulus table
    // ----------------------------------------
    task automatic add_row(input int kind, input alu_op_e op, input logic size,
                           input logic cin, input byte_t jcc, input word_t a,
                           input word_t b, input logic rnd_ce);
        row_t        row;
        logic [18:0] res;
        logic        cf;
        logic        zf;
        logic        sf;
        row = '{kind, op, size, cin, jcc, a, b, rnd_ce, 16'h0, 16'h0, 1'b0};
        cf  = cin;
        zf  = 1'b0;
        sf  = 1'b0;
        if (kind == K_ALU) begin
            res = alu_model(op, size, cin, a, b);
            {cf, zf, sf} = res[18:16];
            row.exp_ax = (op == CMP) ? a : (size ? res[15:0] : {a[15:8], res[7:0]});
        end else if (kind == K_INCDEC) begin
            row.exp_reg = (op == SUB) ? a - 16'd1 : a + 16'd1;
            zf = row.exp_reg == 16'h0;
            sf = row.exp_reg[15];
        end else begin
            row.exp_ax = {b[7:0], a[7:0]};
        end
        // Marker store sits behind the jump, so it lands only when not taken
        row.exp_marker = !((jcc == JZ) ? zf : (jcc == JS) ? sf : cf);
        rows.push_back(row);
    endtask

    task automatic put_byte(inout addr_t p, input byte_t v);
        mem[p] <= v;
        p = p + 16'd1;
    endtask

    task automatic build_program(input row_t row, output addr_t hlt);
        addr_t p;
        p = '0;
        for (int i = 0; i < 65536; i++) begin
            mem[i] <= fill_byte(i);
        end
        put_byte(p, row.cin ? 8'hF9 : 8'hF8);
        if (row.kind == K_ALU) begin
            put_byte(p, 8'hB8);
            put_byte(p, row.a[7:0]);
            put_byte(p, row.a[15:8]);
            put_byte(p, {2'b00, row.op, 2'b10, row.size});
            put_byte(p, row.b[7:0]);
            if (row.size) begin
                put_byte(p, row.b[15:8]);
            end
        end else if (row.kind == K_INCDEC) begin
            put_byte(p, {5'b10111, row.b[2:0]});
            put_byte(p, row.a[7:0]);
            put_byte(p, row.a[15:8]);
            put_byte(p, {(row.op == SUB) ? 5'b01001 : 5'b01000, row.b[2:0]});
        end else begin
            mem[16'h9000] <= row.a[7:0];
            mem[16'h9001] <= row.a[15:8];
            put_byte(p, 8'hA1);
            put_byte(p, 8'h00);
            put_byte(p, 8'h90);
            // Copy of the loaded word before AH is overwritten
            put_byte(p, 8'hA3);
            put_byte(p, 8'h20);
            put_byte(p, 8'h80);
            put_byte(p, 8'hB4);
            put_byte(p, row.b[7:0]);
        end
        // Store AX, conditional hop over the marker store, halt
        put_byte(p, 8'hA3);
        put_byte(p, 8'h00);
        put_byte(p, 8'h80);
        put_byte(p, row.jcc);
        put_byte(p, 8'h03);
        put_byte(p, 8'hA3);
        put_byte(p, 8'h10);
        put_byte(p, 8'h80);
        hlt = p;
        put_byte(p, 8'hF4);
    endtask

    task automatic run_row(input row_t row);
        addr_t hlt;
        word_t marker;
        @(negedge clock);
        reset_n = 1'b0;
        ce      = 1'b1;
        build_program(row, hlt);
        repeat (8) @(posedge clock);
        @(negedge clock);
        check("address", address, 16'h0000);
        reset_n = 1'b1;
        repeat (ROW_CYCLES) begin
            @(negedge clock);
            ce = row.rnd_ce ? ($random(seed) % 2 != 0) : 1'b1;
        end
        @(negedge clock);
        marker = row.exp_marker ? row.exp_ax : {fill_byte(16'h8011), fill_byte(16'h8010)};
        check("address", address, hlt);
        check("mem[8000]", mem_word(16'h8000), row.exp_ax);
        check("mem[8010]", mem_word(16'h8010), marker);
        if (row.kind == K_MEM) begin
            check("mem[8020]", mem_word(16'h8020), row.a);
        end
        if (row.kind == K_INCDEC) begin
            check("regs", i_core_top.i_core_regfile.regs[row.b[2:0]], row.exp_reg);
        end
    endtask

    // Main sequence
    // ----------------------------------------
    initial begin
        seed       = 29111;
        errors     = 0;
        checks     = 0;
        cur_row    = 0;
        rows_ready = 1'b0;
        clock      = 1'b0;
        reset_n    = 1'b0;
        ce         = 1'b1;
        for (int i = 0; i < 8; i++) begin
            for (int sz = 0; sz < 2; sz++) begin
                add_row(K_ALU, alu_op_e'(i), sz[0], 1'b0, JC, 16'h80FF, 16'h7F81, 1'b0);
                add_row(K_ALU, alu_op_e'(i), sz[0], 1'b1, JC, word_t'($random(seed)),
                        word_t'($random(seed)), 1'b0);
            end
        end
        // Carry in decides the carry out here
        add_row(K_ALU, ADC, 1'b1, 1'b1, JC, 16'hFFFF, 16'h0000, 1'b0);
        add_row(K_ALU, SBB, 1'b0, 1'b1, JC, 16'h3400, 16'h0000, 1'b0);
        add_row(K_ALU, SUB, 1'b1, 1'b0, JZ, 16'h1234, 16'h1234, 1'b0);
        add_row(K_ALU, CMP, 1'b0, 1'b0, JZ, 16'h5566, 16'h0066, 1'b0);
        add_row(K_ALU, SUB, 1'b1, 1'b0, JS, 16'h0001, 16'h0002, 1'b0);
        add_row(K_ALU, XOR, 1'b0, 1'b0, JS, 16'h0080, 16'h0001, 1'b0);
        add_row(K_ALU, AND, 1'b1, 1'b0, JZ, word_t'($random(seed)), word_t'($random(seed)), 1'b0);
        add_row(K_ALU, ADD, 1'b0, 1'b0, JS, word_t'($random(seed)), word_t'($random(seed)), 1'b0);
        for (int i = 1; i < 8; i++) begin
            add_row(K_INCDEC, i[0] ? ADD : SUB, 1'b1, i[1], JC, word_t'($random(seed)),
                    word_t'(i), 1'b0);
        end
        add_row(K_INCDEC, ADD, 1'b1, 1'b1, JZ, 16'hFFFF, 16'h0002, 1'b0);
        add_row(K_INCDEC, SUB, 1'b1, 1'b0, JS, 16'h0000, 16'h0006, 1'b0);
        add_row(K_MEM, ADD, 1'b0, 1'b0, JC, 16'hA55A, 16'h003C, 1'b0);
        add_row(K_MEM, ADD, 1'b0, 1'b1, JC, word_t'($random(seed)), word_t'($random(seed)), 1'b0);
        // Same programs with ce high and with ce toggling
        for (int i = 0; i < 2; i++) begin
            add_row(K_ALU, SBB, 1'b1, 1'b1, JC, 16'h1200, 16'h3400, i[0]);
            add_row(K_MEM, ADD, 1'b0, 1'b0, JC, 16'hBEEF, 16'h0011, i[0]);
            add_row(K_INCDEC, SUB, 1'b1, 1'b1, JC, 16'h8000, 16'h0005, i[0]);
        end
        rows_ready = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            cur_row = i;
            run_row(rows[i]);
        end
        $display("Finished %0d rows: %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (rows_ready);
        repeat (rows.size() * (ROW_CYCLES + 12) + 100) @(posedge clock);
        $display("Timeout: the rows did not complete in the expected number of cycles");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
logic/core_pkg.sv
logic/core_alu.sv
logic/core_regfile.sv
logic/core_sequencer.sv
logic/core_top.sv
dv/core_sva.sv
dv/core_tb.sv

/* logic/core_alu.sv */
// Combinational byte/word ALU for the eight 8088 arithmetic and logic operations
`timescale 1ns/1ps

module core_alu import core_pkg::*; (
    input  alu_req_t req,
    output alu_res_t res
);

    logic [16:0] sum;
    logic [16:0] carries;
    logic        cin;
    logic        arith;
    logic        cf;
    logic        of;
    word_t       r;

    // Only ADC and SBB take the incoming carry
    assign cin = req.carry_in && (req.op == ADC || req.op == SBB);

    always_comb begin
        sum   = '0;
        arith = 1'b1;
        case (req.op)
            ADD, ADC: begin
                sum = {1'b0, req.op1} + {1'b0, req.op2} + {16'd0, cin};
            end
            SUB, SBB, CMP: begin
                sum = {1'b0, req.op1} - {1'b0, req.op2} - {16'd0, cin};
            end
            OR: begin
                sum   = {1'b0, req.op1 | req.op2};
                arith = 1'b0;
            end
            AND: begin
                sum   = {1'b0, req.op1 & req.op2};
                arith = 1'b0;
            end
            default: begin
                sum   = {1'b0, req.op1 ^ req.op2};
                arith = 1'b0;
            end
        endcase
    end

    // Carry or borrow into each bit position, bit 16 is the word carry out
    assign carries = sum ^ {1'b0, req.op1} ^ {1'b0, req.op2};
    assign r       = sum[15:0];

    // Taken at the top bit of the active width
    assign cf = arith && (req.size ? carries[16] : carries[8]);
    assign of = arith && (req.size ? (carries[16] ^ carries[15]) : (carries[8] ^ carries[7]));

    always_comb begin
        res.result         = r;
        res.flags          = '0;
        res.flags[CF_BIT]  = cf;
        res.flags[PF_BIT]  = ~^r[7:0];
        res.flags[AF_BIT]  = arith && carries[4];
        res.flags[ZF_BIT]  = req.size ? (r == 16'd0) : (r[7:0] == 8'd0);
        res.flags[SF_BIT]  = req.size ? r[15] : r[7];
        res.flags[OF_BIT]  = of;
    end

endmodule

/* logic/core_pkg.sv */
// Shared types, encodings and flag positions, imported by every block of the core
package core_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [15:0] flags_t;

    // Register numbers in opcode encoding order
    typedef enum reg_idx_t {
        AX, CX, DX, BX, SP, BP, SI, DI
    } reg_idx_e;

    // Byte registers reuse the same numbers
    localparam reg_idx_t AL = 3'd0;
    localparam reg_idx_t CL = 3'd1;
    localparam reg_idx_t DL = 3'd2;
    localparam reg_idx_t BL = 3'd3;
    localparam reg_idx_t AH = 3'd4;
    localparam reg_idx_t CH = 3'd5;
    localparam reg_idx_t DH = 3'd6;
    localparam reg_idx_t BH = 3'd7;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ADD, OR, ADC, SBB, AND, SUB, XOR, CMP
    } alu_op_e;

    localparam int CF_BIT = 0;
    localparam int PF_BIT = 2;
    localparam int AF_BIT = 4;
    localparam int ZF_BIT = 6;
    localparam int SF_BIT = 7;
    localparam int OF_BIT = 11;

    typedef enum logic [1:0] {
        LOAD, RUN, WB, HALT
    } state_e;

    typedef struct packed {
        logic     enable;
        logic     word;
        reg_idx_t index;
        word_t    data;
    } reg_write_t;

    typedef struct packed {
        alu_op_e op;
        logic    size;
        logic    carry_in;
        word_t   op1;
        word_t   op2;
    } alu_req_t;

    typedef struct packed {
        word_t  result;
        flags_t flags;
    } alu_res_t;

endpackage

/* logic/core_regfile.sv */
// General register file AX..DI with byte writes to AL..BH, read combinationally
`timescale 1ns/1ps

module core_regfile import core_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       ce,
    input  reg_write_t reg_wr,
    input  reg_idx_t   rd_a,
    input  reg_idx_t   rd_b,
    output word_t      rd_a_data,
    output word_t      rd_b_data
);

    word_t regs [8];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ce && reg_wr.enable) begin
            if (reg_wr.word) begin
                regs[reg_wr.index] <= reg_wr.data;
            end else begin
                case (reg_wr.index)
                    AL, CL, DL, BL: begin
                        regs[reg_wr.index][7:0] <= reg_wr.data[7:0];
                    end
                    // Indices 4..7 are the high halves of AX..BX
                    AH, CH, DH, BH: begin
                        regs[{1'b0, reg_wr.index[1:0]}][15:8] <= reg_wr.data[7:0];
                    end
                endcase
            end
        end
    end

    // Full words; byte selection is up to the reader
    assign rd_a_data = regs[rd_a];
    assign rd_b_data = regs[rd_b];

endmodule

/* logic/core_sequencer.sv */
// Fetch and execute control of the core; owns IP, flags and the memory bus
`timescale 1ns/1ps

module core_sequencer import core_pkg::*; (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       ce,
    output addr_t      address,
    input  byte_t      in,
    output byte_t      out,
    output logic       we,
    output reg_write_t reg_wr,
    output reg_idx_t   rd_a,
    output reg_idx_t   rd_b,
    input  word_t      rd_a_data,
    input  word_t      rd_b_data,
    output alu_req_t   alu_req,
    input  alu_res_t   alu_res
);

    localparam flags_t ARITH_MASK = (flags_t'(1) << CF_BIT) | (flags_t'(1) << PF_BIT) |
                                    (flags_t'(1) << AF_BIT) | (flags_t'(1) << ZF_BIT) |
                                    (flags_t'(1) << SF_BIT) | (flags_t'(1) << OF_BIT);
    // INC and DEC leave the carry alone
    localparam flags_t INCDEC_MASK = ARITH_MASK & ~(flags_t'(1) << CF_BIT);

    state_e     state;
    addr_t      ip;
    addr_t      ea;
    byte_t      opcode;
    logic [1:0] m;
    word_t      wb;
    flags_t     flags;

    logic is_alu_i;
    logic is_incdec;
    logic is_acc_mem;
    logic is_mov_i;
    logic cond;
    logic jcc_taken;

    function automatic flags_t merge_flags(flags_t cur, flags_t alu, flags_t mask);
        return (cur & ~mask) | (alu & mask);
    endfunction

    // Instruction classes of the latched opcode
    assign is_alu_i   = (opcode[7:6] == 2'b00) && (opcode[2:1] == 2'b10);
    assign is_incdec  = (opcode[7:4] == 4'h4);
    assign is_acc_mem = (opcode[7:2] == 6'b1010_00);
    assign is_mov_i   = (opcode[7:4] == 4'hB);

    // Jcc condition table, odd opcodes negate
    always_comb begin
        case (in[3:1])
            3'd0:    cond = flags[OF_BIT];
            3'd1:    cond = flags[CF_BIT];
            3'd2:    cond = flags[ZF_BIT];
            3'd3:    cond = flags[CF_BIT] | flags[ZF_BIT];
            3'd4:    cond = flags[SF_BIT];
            3'd5:    cond = flags[PF_BIT];
            3'd6:    cond = flags[SF_BIT] ^ flags[OF_BIT];
            default: cond = (flags[SF_BIT] ^ flags[OF_BIT]) | flags[ZF_BIT];
        endcase
    end

    assign jcc_taken = cond ^ in[0];

    // Bus side
    // ----------------------------------------
    // Data cycles of A0..A3 are m = 2 and m = 3
    assign address = (state == RUN && is_acc_mem && m[1]) ? ea : ip;
    assign we      = ce && state == RUN && is_acc_mem && opcode[1] && m[1];
    assign out     = m[0] ? rd_a_data[15:8] : rd_a_data[7:0];

    // Port A is the accumulator, port B the register named in the opcode
    assign rd_a = AX;
    assign rd_b = opcode[2:0];

    always_comb begin
        alu_req.op       = is_incdec ? (opcode[3] ? SUB : ADD) : alu_op_e'(opcode[5:3]);
        alu_req.size     = is_incdec | opcode[0];
        alu_req.carry_in = flags[CF_BIT];
        alu_req.op1      = is_incdec ? rd_b_data : rd_a_data;
        alu_req.op2      = is_incdec ? 16'd1 : wb;
    end

    // Register writes
    always_comb begin
        reg_wr = '0;
        case (state)
            RUN: begin
                // Last immediate byte of MOV r,imm
                if (is_mov_i && m == {1'b0, opcode[3]}) begin
                    reg_wr.enable = 1'b1;
                    reg_wr.word   = opcode[3];
                    reg_wr.index  = opcode[2:0];
                    reg_wr.data   = opcode[3] ? {in, wb[7:0]} : {8'h00, in};
                end
                // Loaded byte into AL then AH
                if (is_acc_mem && !opcode[1] && m[1]) begin
                    reg_wr.enable = 1'b1;
                    reg_wr.word   = 1'b0;
                    reg_wr.index  = m[0] ? AH : AL;
                    reg_wr.data   = {8'h00, in};
                end
            end
            WB: begin
                reg_wr.enable = (alu_req.op != CMP);
                reg_wr.word   = alu_req.size;
                reg_wr.index  = is_incdec ? opcode[2:0] : reg_idx_t'(AX);
                reg_wr.data   = is_incdec ? wb : alu_res.result;
            end
            default: ;
        endcase
    end

    // State machine
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state  <= LOAD;
            ip     <= '0;
            m      <= '0;
            opcode <= '0;
            flags  <= '0;
        end else if (ce) begin
            case (state)
                LOAD: begin
                    opcode <= in;
                    m      <= '0;
                    ip     <= ip + 16'd1;
                    casez (in)
                        8'b00??_?10?, 8'b0100_????, 8'b1010_00??, 8'b1011_????, 8'hEB: begin
                            state <= RUN;
                        end
                        8'b0111_????: begin
                            if (jcc_taken) begin
                                state <= RUN;
                            end else begin
                                ip <= ip + 16'd2;
                            end
                        end
                        8'hF4: begin
                            ip    <= ip;
                            state <= HALT;
                        end
                        8'hF5: flags[CF_BIT] <= ~flags[CF_BIT];
                        8'hF8, 8'hF9: flags[CF_BIT] <= in[0];
                        default: ;
                    endcase
                end
                RUN: begin
                    if (is_alu_i) begin
                        if (m == 2'd0) begin
                            wb <= {8'h00, in};
                        end else begin
                            wb[15:8] <= in;
                        end
                        ip <= ip + 16'd1;
                        m  <= m + 2'd1;
                        if (m == 2'd1 || !opcode[0]) begin
                            state <= WB;
                        end
                    end else if (is_incdec) begin
                        wb    <= alu_res.result;
                        flags <= merge_flags(flags, alu_res.flags, INCDEC_MASK);
                        state <= WB;
                    end else if (is_acc_mem) begin
                        m <= m + 2'd1;
                        case (m)
                            2'd0: begin
                                ea[7:0] <= in;
                                ip      <= ip + 16'd1;
                            end
                            2'd1: begin
                                ea[15:8] <= in;
                                ip       <= ip + 16'd1;
                            end
                            2'd2: begin
                                ea <= ea + 16'd1;
                                if (!opcode[0]) begin
                                    state <= LOAD;
                                end
                            end
                            default: state <= LOAD;
                        endcase
                    end else if (is_mov_i) begin
                        wb[7:0] <= in;
                        ip      <= ip + 16'd1;
                        m       <= m + 2'd1;
                        if (m == 2'd1 || !opcode[3]) begin
                            state <= LOAD;
                        end
                    end else begin
                        // Taken Jcc or JMP short
                        ip    <= ip + 16'd1 + {{8{in[7]}}, in};
                        state <= LOAD;
                    end
                end
                WB: begin
                    if (is_alu_i) begin
                        flags <= merge_flags(flags, alu_res.flags, ARITH_MASK);
                    end
                    state <= LOAD;
                end
                // HALT waits for reset
                default: ;
            endcase
        end
    end

endmodule

/* logic/core_top.sv */
// Top level of the 8088 subset core; connect a byte-wide memory with combinational read
`timescale 1ns/1ps

module core_top import core_pkg::*; (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  ce,
    output addr_t address,
    input  byte_t in,
    output byte_t out,
    output logic  we
);

    reg_write_t reg_wr;
    reg_idx_t   rd_a;
    reg_idx_t   rd_b;
    word_t      rd_a_data;
    word_t      rd_b_data;
    alu_req_t   alu_req;
    alu_res_t   alu_res;

    core_sequencer i_core_sequencer (
        .clock     (clock),
        .reset_n   (reset_n),
        .ce        (ce),
        .address   (address),
        .in        (in),
        .out       (out),
        .we        (we),
        .reg_wr    (reg_wr),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .alu_req   (alu_req),
        .alu_res   (alu_res)
    );

    core_regfile i_core_regfile (
        .clock     (clock),
        .reset_n   (reset_n),
        .ce        (ce),
        .reg_wr    (reg_wr),
        .rd_a      (rd_a),
        .rd_b      (rd_b),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data)
    );

    core_alu i_core_alu (
        .req (alu_req),
        .res (alu_res)
    );

endmodule
